/* hdl/exmon_defs.svh */
// Exclusive monitor parameters
`ifndef EXMON_DEFS_SVH
`define EXMON_DEFS_SVH

// transaction id width.
`define EXMON_ID_W 4

// byte address width.
`define EXMON_ADDR_W 32

// data word width, a multiple of 8.
`define EXMON_DATA_W 32

// reservation entries, a power of two.
`define EXMON_NUM_ENT 4

// width of the outstanding normal transaction counters.
`define EXMON_PEND_W 4

// reset value of the victim lfsr, never zero.
`define EXMON_LFSR_SEED 8'hA5

`endif

/* hdl/exmon_pkg.sv */
// Exclusive monitor types
`include "exmon_defs.svh"

package exmon_pkg;

	typedef logic [`EXMON_ID_W-1:0] id_t;
	typedef logic [`EXMON_ADDR_W-1:0] addr_t;
	typedef logic [2:0] size_t; // log2 of bytes per access.
	typedef logic [`EXMON_DATA_W-1:0] data_t;
	typedef logic [`EXMON_DATA_W/8-1:0] strb_t;
	typedef logic [1:0] resp_t;
	typedef logic [$clog2(`EXMON_NUM_ENT)-1:0] ent_idx_t;

	localparam resp_t resp_okay = 2'b00;
	localparam resp_t resp_exokay = 2'b01;
	localparam resp_t resp_slverr = 2'b10;
	localparam resp_t resp_decerr = 2'b11;

	// read request, also the reservation record.
	typedef struct packed {
		id_t id;
		addr_t addr;
		size_t size;
		logic excl;
	} rd_req_t;

	// write request with its single data beat.
	typedef struct packed {
		id_t id;
		addr_t addr;
		size_t size;
		logic excl;
		data_t data;
		strb_t strb;
	} wr_req_t;

	typedef struct packed {
		id_t id;
		data_t data;
		resp_t resp;
	} rd_rsp_t;

	typedef struct packed {
		id_t id;
		resp_t resp;
	} wr_rsp_t;

	typedef enum logic [1:0] {
		gate_idle,
		gate_ex_read,
		gate_ex_write
	} gate_state_t;

endpackage

/* hdl/exmon_request_gate.sv */
// Exclusive request gate
`timescale 1ns/1ps
`include "exmon_defs.svh"

module exmon_request_gate (
	input  logic aclk,
	input  logic aresetn,
	input  exmon_pkg::rd_req_t us_rd_req,
	input  logic us_rd_valid,
	output logic us_rd_ready,
	input  exmon_pkg::wr_req_t us_wr_req,
	input  logic us_wr_valid,
	output logic us_wr_ready,
	output exmon_pkg::rd_req_t ds_rd_req,
	output logic ds_rd_valid,
	input  logic ds_rd_ready,
	output exmon_pkg::wr_req_t ds_wr_req,
	output logic ds_wr_valid,
	input  logic ds_wr_ready,
	input  logic wr_match,
	input  logic rd_rsp_done,
	input  logic wr_rsp_done,
	output logic rd_ex_issue,
	output logic wr_normal_issue,
	output logic wr_ex_issue,
	output logic ex_read_active,
	output logic ex_write_active
);
	import exmon_pkg::*;

	gate_state_t state;
	gate_state_t state_nxt;
	logic [`EXMON_PEND_W-1:0] rd_cnt;
	logic [`EXMON_PEND_W-1:0] wr_cnt;
	logic rd_hold;
	logic wr_hold;
	logic is_idle;
	logic no_pending;
	logic rd_ex_req;
	logic rd_ok;
	logic wr_ok;
	logic rd_normal_issue;
	logic rd_normal_done;
	logic wr_normal_done;

	assign is_idle = (state == gate_idle);
	assign no_pending = (rd_cnt == '0) && (wr_cnt == '0);
	assign rd_ex_req = us_rd_valid & us_rd_req.excl;

	// a request already shown downstream keeps its grant until it transfers
	assign rd_ok = is_idle & (rd_hold | (us_rd_req.excl ? (no_pending & ~wr_hold)
		: (~(&rd_cnt) & ~(wr_hold & us_wr_req.excl))));
	assign wr_ok = is_idle & (wr_hold | (us_wr_req.excl
		? (no_pending & ~rd_hold & ~us_rd_valid) // reads win.
		: (~(&wr_cnt) & ~rd_ex_req)));

	assign ds_rd_valid = us_rd_valid & rd_ok;
	assign us_rd_ready = ds_rd_ready & rd_ok;
	assign ds_wr_valid = us_wr_valid & wr_ok;
	assign us_wr_ready = ds_wr_ready & wr_ok;

	always_comb begin
		ds_rd_req = us_rd_req;
		ds_rd_req.excl = 1'b0;
		ds_wr_req = us_wr_req;
		ds_wr_req.excl = 1'b0;
		if (us_wr_req.excl && !wr_match)
			ds_wr_req.strb = '0; // failed store must not touch memory.
	end

	assign rd_ex_issue = ds_rd_valid & ds_rd_ready & us_rd_req.excl;
	assign rd_normal_issue = ds_rd_valid & ds_rd_ready & ~us_rd_req.excl;
	assign wr_ex_issue = ds_wr_valid & ds_wr_ready & us_wr_req.excl;
	assign wr_normal_issue = ds_wr_valid & ds_wr_ready & ~us_wr_req.excl;

	assign rd_normal_done = rd_rsp_done & ~ex_read_active;
	assign wr_normal_done = wr_rsp_done & ~ex_write_active;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rd_cnt <= '0;
			wr_cnt <= '0;
			rd_hold <= 1'b0;
			wr_hold <= 1'b0;
		end else begin
			if (rd_normal_issue && !rd_normal_done)
				rd_cnt <= rd_cnt + 1'b1;
			else if (!rd_normal_issue && rd_normal_done)
				rd_cnt <= rd_cnt - 1'b1;
			if (wr_normal_issue && !wr_normal_done)
				wr_cnt <= wr_cnt + 1'b1;
			else if (!wr_normal_issue && wr_normal_done)
				wr_cnt <= wr_cnt - 1'b1;
			rd_hold <= ds_rd_valid & ~ds_rd_ready;
			wr_hold <= ds_wr_valid & ~ds_wr_ready;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			gate_idle: begin
				if (rd_ex_issue)
					state_nxt = gate_ex_read;
				else if (wr_ex_issue)
					state_nxt = gate_ex_write;
			end
			gate_ex_read: begin
				if (rd_rsp_done)
					state_nxt = gate_idle;
			end
			gate_ex_write: begin
				if (wr_rsp_done)
					state_nxt = gate_idle;
			end
			default: state_nxt = gate_idle;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			state <= gate_idle;
		else
			state <= state_nxt;
	end

	assign ex_read_active = (state == gate_ex_read);
	assign ex_write_active = (state == gate_ex_write);

endmodule

/* hdl/exmon_reservation_table.sv */
// Exclusive reservation table
`timescale 1ns/1ps
`include "exmon_defs.svh"

module exmon_reservation_table (
	input  logic aclk,
	input  logic aresetn,
	input  logic rd_ex_issue,
	input  exmon_pkg::rd_req_t rd_req,
	input  logic rd_ex_okay,
	input  exmon_pkg::wr_req_t wr_req,
	input  logic wr_normal_issue,
	input  logic wr_ex_issue,
	output logic wr_match,
	output logic wr_pass
);
	import exmon_pkg::*;

	localparam int NUM_ENT = `EXMON_NUM_ENT;

	rd_req_t pend_rd; // exclusive read waiting for its response.
	rd_req_t ent [NUM_ENT];
	logic [NUM_ENT-1:0] ent_valid;
	logic [NUM_ENT-1:0] addr_hit;
	logic [NUM_ENT-1:0] full_hit;
	logic [7:0] lfsr;
	logic id_found;
	logic free_found;
	ent_idx_t id_idx;
	ent_idx_t free_idx;
	ent_idx_t set_idx;

	// compare the presented write against every live entry
	always_comb begin
		for (int i = 0; i < NUM_ENT; i++) begin
			addr_hit[i] = ent_valid[i] && (ent[i].addr == wr_req.addr);
			full_hit[i] = addr_hit[i] && (ent[i].id == wr_req.id)
				&& (ent[i].size == wr_req.size);
		end
	end

	assign wr_match = |full_hit;

	// same id first, then lowest free slot, then the lfsr victim
	always_comb begin
		id_found = 1'b0;
		id_idx = '0;
		free_found = 1'b0;
		free_idx = '0;
		for (int i = NUM_ENT - 1; i >= 0; i--) begin
			if (ent_valid[i] && (ent[i].id == pend_rd.id)) begin
				id_found = 1'b1;
				id_idx = ent_idx_t'(i);
			end
			if (!ent_valid[i]) begin
				free_found = 1'b1;
				free_idx = ent_idx_t'(i); // ends on the lowest.
			end
		end
		if (id_found)
			set_idx = id_idx;
		else if (free_found)
			set_idx = free_idx;
		else
			set_idx = ent_idx_t'(lfsr);
	end

	always_ff @(posedge aclk) begin
		if (rd_ex_issue)
			pend_rd <= rd_req;
		if (rd_ex_okay)
			ent[set_idx] <= pend_rd;
	end

	// sets only happen in the exclusive read phase, so they never meet a clear
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			ent_valid <= '0;
			lfsr <= `EXMON_LFSR_SEED;
			wr_pass <= 1'b0;
		end else begin
			if (rd_ex_okay) begin
				ent_valid[set_idx] <= 1'b1;
				lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			end
			if (wr_normal_issue || (wr_ex_issue && wr_match))
				ent_valid <= ent_valid & ~addr_hit; // drop every entry on this address.
			if (wr_ex_issue)
				wr_pass <= wr_match;
		end
	end

endmodule

/* hdl/exmon_response_rewrite.sv */
// Exclusive response rewrite
`timescale 1ns/1ps
`include "exmon_defs.svh"

module exmon_response_rewrite (
	input  exmon_pkg::rd_rsp_t ds_rd_rsp,
	input  logic ds_rd_valid,
	output logic ds_rd_ready,
	output exmon_pkg::rd_rsp_t us_rd_rsp,
	output logic us_rd_valid,
	input  logic us_rd_ready,
	input  exmon_pkg::wr_rsp_t ds_wr_rsp,
	input  logic ds_wr_valid,
	output logic ds_wr_ready,
	output exmon_pkg::wr_rsp_t us_wr_rsp,
	output logic us_wr_valid,
	input  logic us_wr_ready,
	input  logic ex_read_active,
	input  logic ex_write_active,
	input  logic wr_pass,
	output logic rd_rsp_done,
	output logic wr_rsp_done,
	output logic rd_ex_okay
);
	import exmon_pkg::*;

	assign us_rd_valid = ds_rd_valid;
	assign ds_rd_ready = us_rd_ready;
	assign us_wr_valid = ds_wr_valid;
	assign ds_wr_ready = us_wr_ready;

	assign rd_rsp_done = ds_rd_valid & us_rd_ready;
	assign wr_rsp_done = ds_wr_valid & us_wr_ready;

	// slave errors and decode errors go up untouched
	always_comb begin
		us_rd_rsp = ds_rd_rsp;
		if (ex_read_active && (ds_rd_rsp.resp == resp_okay))
			us_rd_rsp.resp = resp_exokay;
	end

	always_comb begin
		us_wr_rsp = ds_wr_rsp;
		if (ex_write_active && wr_pass && (ds_wr_rsp.resp == resp_okay))
			us_wr_rsp.resp = resp_exokay;
	end

	// only a clean exclusive read may leave a reservation behind
	assign rd_ex_okay = rd_rsp_done & ex_read_active & (ds_rd_rsp.resp == resp_okay);

endmodule

/* hdl/exmon_top.sv */
// Exclusive access monitor
`timescale 1ns/1ps
`include "exmon_defs.svh"

module exmon_top (
	input  logic aclk,
	input  logic aresetn,
	input  exmon_pkg::rd_req_t us_rd_req,
	input  logic us_rd_req_valid,
	output logic us_rd_req_ready,
	output exmon_pkg::rd_req_t ds_rd_req,
	output logic ds_rd_req_valid,
	input  logic ds_rd_req_ready,
	input  exmon_pkg::wr_req_t us_wr_req,
	input  logic us_wr_req_valid,
	output logic us_wr_req_ready,
	output exmon_pkg::wr_req_t ds_wr_req,
	output logic ds_wr_req_valid,
	input  logic ds_wr_req_ready,
	input  exmon_pkg::rd_rsp_t ds_rd_rsp,
	input  logic ds_rd_rsp_valid,
	output logic ds_rd_rsp_ready,
	output exmon_pkg::rd_rsp_t us_rd_rsp,
	output logic us_rd_rsp_valid,
	input  logic us_rd_rsp_ready,
	input  exmon_pkg::wr_rsp_t ds_wr_rsp,
	input  logic ds_wr_rsp_valid,
	output logic ds_wr_rsp_ready,
	output exmon_pkg::wr_rsp_t us_wr_rsp,
	output logic us_wr_rsp_valid,
	input  logic us_wr_rsp_ready
);
	logic rd_ex_issue;
	logic wr_normal_issue;
	logic wr_ex_issue;
	logic wr_match;
	logic wr_pass;
	logic ex_read_active;
	logic ex_write_active;
	logic rd_rsp_done;
	logic wr_rsp_done;
	logic rd_ex_okay;

	exmon_request_gate request_gate_inst (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.us_rd_req       (us_rd_req),
		.us_rd_valid     (us_rd_req_valid),
		.us_rd_ready     (us_rd_req_ready),
		.us_wr_req       (us_wr_req),
		.us_wr_valid     (us_wr_req_valid),
		.us_wr_ready     (us_wr_req_ready),
		.ds_rd_req       (ds_rd_req),
		.ds_rd_valid     (ds_rd_req_valid),
		.ds_rd_ready     (ds_rd_req_ready),
		.ds_wr_req       (ds_wr_req),
		.ds_wr_valid     (ds_wr_req_valid),
		.ds_wr_ready     (ds_wr_req_ready),
		.wr_match        (wr_match),
		.rd_rsp_done     (rd_rsp_done),
		.wr_rsp_done     (wr_rsp_done),
		.rd_ex_issue     (rd_ex_issue),
		.wr_normal_issue (wr_normal_issue),
		.wr_ex_issue     (wr_ex_issue),
		.ex_read_active  (ex_read_active),
		.ex_write_active (ex_write_active)
	);

	exmon_reservation_table reservation_table_inst (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.rd_ex_issue     (rd_ex_issue),
		.rd_req          (ds_rd_req), // accepted read, flag stripped.
		.rd_ex_okay      (rd_ex_okay),
		.wr_req          (us_wr_req),
		.wr_normal_issue (wr_normal_issue),
		.wr_ex_issue     (wr_ex_issue),
		.wr_match        (wr_match),
		.wr_pass         (wr_pass)
	);

	exmon_response_rewrite response_rewrite_inst (
		.ds_rd_rsp       (ds_rd_rsp),
		.ds_rd_valid     (ds_rd_rsp_valid),
		.ds_rd_ready     (ds_rd_rsp_ready),
		.us_rd_rsp       (us_rd_rsp),
		.us_rd_valid     (us_rd_rsp_valid),
		.us_rd_ready     (us_rd_rsp_ready),
		.ds_wr_rsp       (ds_wr_rsp),
		.ds_wr_valid     (ds_wr_rsp_valid),
		.ds_wr_ready     (ds_wr_rsp_ready),
		.us_wr_rsp       (us_wr_rsp),
		.us_wr_valid     (us_wr_rsp_valid),
		.us_wr_ready     (us_wr_rsp_ready),
		.ex_read_active  (ex_read_active),
		.ex_write_active (ex_write_active),
		.wr_pass         (wr_pass),
		.rd_rsp_done     (rd_rsp_done),
		.wr_rsp_done     (wr_rsp_done),
		.rd_ex_okay      (rd_ex_okay)
	);

endmodule

/* test/exmon_tb.sv */
// Exclusive monitor testbench
`timescale 1ns/1ps
`include "exmon_defs.svh"

module exmon_tb;
	import exmon_pkg::*;

	localparam addr_t A0 = 32'h0000_0100;
	localparam addr_t A1 = 32'h0000_0104;
	localparam addr_t A2 = 32'h0000_0108;
	localparam addr_t ERR_ADDR = 32'h0000_010C; // responder answers slverr here.
	localparam int NUM_RAND = 300;
	localparam int TIMEOUT_CYC = NUM_RAND * 12;

	logic aclk;
	logic aresetn;
	rd_req_t us_rd_req, ds_rd_req;
	wr_req_t us_wr_req, ds_wr_req;
	rd_rsp_t ds_rd_rsp, us_rd_rsp;
	wr_rsp_t ds_wr_rsp, us_wr_rsp;
	logic us_rd_req_valid, us_rd_req_ready, ds_rd_req_valid, ds_rd_req_ready;
	logic us_wr_req_valid, us_wr_req_ready, ds_wr_req_valid, ds_wr_req_ready;
	logic ds_rd_rsp_valid, ds_rd_rsp_ready, us_rd_rsp_valid, us_rd_rsp_ready;
	logic ds_wr_rsp_valid, ds_wr_rsp_ready, us_wr_rsp_valid, us_wr_rsp_ready;

	data_t mem [4]; // memory behind the monitor.
	data_t ref_mem [4];
	rd_req_t ds_rd_exp; // request the memory should see.
	wr_req_t ds_wr_exp;
	logic res_valid [1 << `EXMON_ID_W];
	addr_t res_addr [1 << `EXMON_ID_W];
	size_t res_size [1 << `EXMON_ID_W];
	logic [31:0] seed;
	int rsp_delay;
	int errors;
	int checks;
	int cycles;

	exmon_top exmon_top_inst (.*);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic data_t fill_word(input addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
	endfunction

	// expected response from the exclusive access rules
	function automatic rd_rsp_t predict_rsp(input logic wr, input logic excl, input id_t id,
		input addr_t addr, input size_t size, input data_t wdata);
		rd_rsp_t r;
		logic hit;
		r.id = id;
		r.data = '0;
		r.resp = resp_okay;
		if (addr == ERR_ADDR) begin
			r.resp = resp_slverr; // nothing is recorded or written.
			return r;
		end
		if (!wr) begin
			r.data = ref_mem[addr[3:2]];
			if (excl) begin
				r.resp = resp_exokay;
				res_valid[id] = 1'b1;
				res_addr[id] = addr;
				res_size[id] = size;
			end
			return r;
		end
		hit = res_valid[id] && (res_addr[id] == addr) && (res_size[id] == size);
		if (excl && !hit)
			return r; // failed store.
		if (excl)
			r.resp = resp_exokay;
		ref_mem[addr[3:2]] = wdata;
		for (int i = 0; i < (1 << `EXMON_ID_W); i++)
			if (res_valid[i] && (res_addr[i] == addr))
				res_valid[i] = 1'b0;
		return r;
	endfunction

	task automatic check_rd_rsp(input rd_rsp_t got, input rd_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: read got id %0h data %h resp %0d, expected id %0h data %h resp %0d",
				$time, got.id, got.data, got.resp, exp.id, exp.data, exp.resp);
		end
	endtask

	task automatic check_wr_rsp(input wr_rsp_t got, input wr_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: write got id %0h resp %0d, expected id %0h resp %0d",
				$time, got.id, got.resp, exp.id, exp.resp);
		end
	endtask

	task automatic check_mem(input addr_t a, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: memory at %h holds %h, expected %h", $time, a, got, exp);
		end
	endtask

	task automatic check_ds_rd_req(input rd_req_t got, input rd_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: downstream read request %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_ds_wr_req(input wr_req_t got, input wr_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: downstream write request %h, expected %h", $time, got, exp);
		end
	endtask

	// returns on the rising edge that completes a transfer on channel ch
	task automatic wait_xfer(input int ch, output rd_rsp_t rd_got, output wr_rsp_t wr_got);
		logic hit;
		hit = 1'b0;
		while (!hit) begin
			@(negedge aclk);
			case (ch)
				0: hit = us_rd_req_ready;
				1: hit = us_wr_req_ready;
				2: hit = us_rd_rsp_valid;
				3: hit = us_wr_rsp_valid;
				4: hit = ds_rd_rsp_ready;
				default: hit = ds_wr_rsp_ready;
			endcase
			rd_got = us_rd_rsp;
			wr_got = us_wr_rsp;
			@(posedge aclk);
		end
	endtask

	task automatic run_txn(input logic wr, input logic excl, input id_t id, input addr_t addr,
		input size_t size, input data_t data);
		rd_rsp_t exp;
		rd_rsp_t rd_got;
		wr_rsp_t wr_got;
		wr_rsp_t exp_wr;
		exp = predict_rsp(wr, excl, id, addr, size, data);
		rsp_delay = int'(lcg_next() >> 30);
		if (wr) begin
			ds_wr_exp = '{id: id, addr: addr, size: size, excl: 1'b0, data: data, strb: '1};
			if (excl && (exp.resp != resp_exokay))
				ds_wr_exp.strb = '0; // a failed store reaches memory with no lanes.
			us_wr_req = '{id: id, addr: addr, size: size, excl: excl, data: data, strb: '1};
			us_wr_req_valid = 1'b1;
			wait_xfer(1, rd_got, wr_got);
			#1 us_wr_req_valid = 1'b0;
			wait_xfer(3, rd_got, wr_got);
			exp_wr.id = id;
			exp_wr.resp = exp.resp;
			check_wr_rsp(wr_got, exp_wr);
		end else begin
			ds_rd_exp = '{id: id, addr: addr, size: size, excl: 1'b0};
			us_rd_req = '{id: id, addr: addr, size: size, excl: excl};
			us_rd_req_valid = 1'b1;
			wait_xfer(0, rd_got, wr_got);
			#1 us_rd_req_valid = 1'b0;
			wait_xfer(2, rd_got, wr_got);
			check_rd_rsp(rd_got, exp);
		end
		#1;
	endtask

	// in-order memory model, one request at a time
	initial begin : responder
		rd_req_t rq;
		wr_req_t wq;
		rd_rsp_t rd_unused;
		wr_rsp_t wr_unused;
		ds_rd_req_ready = 1'b1;
		ds_wr_req_ready = 1'b1;
		ds_rd_rsp = '0;
		ds_rd_rsp_valid = 1'b0;
		ds_wr_rsp = '0;
		ds_wr_rsp_valid = 1'b0;
		for (int i = 0; i < 4; i++)
			mem[i] = fill_word(A0 + addr_t'(4 * i));
		forever begin
			@(negedge aclk);
			if (ds_wr_req_valid) begin
				wq = ds_wr_req;
				check_ds_wr_req(wq, ds_wr_exp);
				if (wq.addr != ERR_ADDR)
					for (int b = 0; b < `EXMON_DATA_W / 8; b++)
						if (wq.strb[b])
							mem[wq.addr[3:2]][8*b +: 8] = wq.data[8*b +: 8];
				@(posedge aclk);
				repeat (rsp_delay) @(posedge aclk);
				#1 ds_wr_rsp = '{id: wq.id, resp: (wq.addr == ERR_ADDR) ? resp_slverr : resp_okay};
				ds_wr_rsp_valid = 1'b1;
				wait_xfer(5, rd_unused, wr_unused);
				#1 ds_wr_rsp_valid = 1'b0;
			end else if (ds_rd_req_valid) begin
				rq = ds_rd_req;
				check_ds_rd_req(rq, ds_rd_exp);
				@(posedge aclk);
				repeat (rsp_delay) @(posedge aclk);
				#1 ds_rd_rsp.id = rq.id;
				ds_rd_rsp.data = (rq.addr == ERR_ADDR) ? '0 : mem[rq.addr[3:2]];
				ds_rd_rsp.resp = (rq.addr == ERR_ADDR) ? resp_slverr : resp_okay;
				ds_rd_rsp_valid = 1'b1;
				wait_xfer(4, rd_unused, wr_unused);
				#1 ds_rd_rsp_valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYC) begin
			@(posedge aclk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a transfer never completed", cycles);
		$display("Errors found");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] r;
		seed = 32'h5549;
		errors = 0;
		checks = 0;
		aresetn = 1'b0;
		us_rd_req = '0;
		us_rd_req_valid = 1'b0;
		us_wr_req = '0;
		us_wr_req_valid = 1'b0;
		us_rd_rsp_ready = 1'b1;
		us_wr_rsp_ready = 1'b1;
		ds_rd_exp = '0;
		ds_wr_exp = '0;
		for (int i = 0; i < 4; i++)
			ref_mem[i] = fill_word(A0 + addr_t'(4 * i));
		for (int i = 0; i < (1 << `EXMON_ID_W); i++)
			res_valid[i] = 1'b0;
		repeat (4) @(posedge aclk);
		#1 aresetn = 1'b1;
		run_txn(1'b1, 1'b0, 4'd1, A0, 3'd2, 32'h1111_1111); // plain traffic.
		run_txn(1'b0, 1'b0, 4'd1, A0, 3'd2, '0);
		run_txn(1'b0, 1'b1, 4'd1, A1, 3'd2, '0); // load and store exclusive pair.
		run_txn(1'b1, 1'b1, 4'd1, A1, 3'd2, 32'h2222_2222);
		run_txn(1'b0, 1'b0, 4'd1, A1, 3'd2, '0);
		run_txn(1'b1, 1'b1, 4'd2, A2, 3'd2, 32'h3333_3333); // no reservation yet.
		run_txn(1'b0, 1'b1, 4'd2, A2, 3'd2, '0);
		run_txn(1'b1, 1'b1, 4'd3, A2, 3'd2, 32'h4444_4444); // other id.
		run_txn(1'b1, 1'b1, 4'd2, A2, 3'd1, 32'h5555_5555); // other size.
		run_txn(1'b0, 1'b0, 4'd2, A2, 3'd2, '0);
		run_txn(1'b0, 1'b1, 4'd1, A0, 3'd2, '0);
		run_txn(1'b1, 1'b0, 4'd3, A0, 3'd2, 32'h6666_6666); // breaks the reservation.
		run_txn(1'b1, 1'b1, 4'd1, A0, 3'd2, 32'h7777_7777);
		run_txn(1'b0, 1'b0, 4'd1, A0, 3'd2, '0);
		run_txn(1'b0, 1'b1, 4'd2, ERR_ADDR, 3'd2, '0);
		run_txn(1'b1, 1'b1, 4'd2, ERR_ADDR, 3'd2, 32'h8888_8888);
		for (int n = 0; n < NUM_RAND; n++) begin
			r = lcg_next();
			run_txn(r[28], r[29], id_t'((r >> 24) % 3 + 1), A0 + addr_t'({r[21:20], 2'b00}),
				(r[27:26] == 2'd0) ? 3'd1 : 3'd2, lcg_next());
		end
		for (int i = 0; i < 4; i++)
			check_mem(A0 + addr_t'(4 * i), mem[i], ref_mem[i]);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* files.f */
+incdir+hdl
hdl/exmon_pkg.sv
hdl/exmon_request_gate.sv
hdl/exmon_reservation_table.sv
hdl/exmon_response_rewrite.sv
hdl/exmon_top.sv
test/exmon_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module exmon_tb -o exmon_sim
	./obj_dir/exmon_sim > sim.log
	cat sim.log
	! grep -q "Errors found" sim.log

clean:
	rm -rf obj_dir sim.log
